// File: Bender.yml
package:
  name: dcache

sources:
  - design/dcache_pkg.sv
  - design/dcache_array.sv
  - design/flush_counter.sv
  - design/dcache_ctrl.sv
  - design/dcache.sv
  - target: simulation
    files:
      - sim/mem_model.sv
      - sim/dcache_tb.sv

// File: design/dcache.sv
//####################
// dcache top
// two-way write-back data cache, 8 sets of 2-word blocks
//####################
`default_nettype none

module dcache import dcache_pkg::*; (
	input  logic     CLK,
	input  logic     nRST,
	input  cpu_req_t cpu_req,
	input  logic     halt,
	output cpu_rsp_t cpu_rsp,
	output logic     flushed,
	output mem_req_t mem_req,
	input  logic     mem_wait,
	input  word_t    mem_rdata
);

	array_cmd_t  cmd;
	lookup_t     lookup;
	word_t       array_rdata;
	tag_t        flush_tag;
	logic        flush_dirty;
	word_t [1:0] flush_words;
	logic        step;
	frame_t      frame;
	logic        done;

	dcache_ctrl u_ctrl (
		.CLK         (CLK),
		.nRST        (nRST),
		.cpu_req     (cpu_req),
		.halt        (halt),
		.lookup      (lookup),
		.rdata       (array_rdata),
		.flush_tag   (flush_tag),
		.flush_dirty (flush_dirty),
		.flush_words (flush_words),
		.frame       (frame),
		.done        (done),
		.mem_wait    (mem_wait),
		.cpu_rsp     (cpu_rsp),
		.flushed     (flushed),
		.cmd         (cmd),
		.step        (step),
		.mem_req     (mem_req)
	);

	dcache_array u_array (
		.CLK         (CLK),
		.nRST        (nRST),
		.addr        (cpu_req.addr),
		.wdata       (cpu_req.wdata),
		.cmd         (cmd),
		.mem_rdata   (mem_rdata),
		.lookup      (lookup),
		.rdata       (array_rdata),
		.flush_tag   (flush_tag),
		.flush_dirty (flush_dirty),
		.flush_words (flush_words)
	);

	flush_counter u_flush_counter (
		.CLK   (CLK),
		.nRST  (nRST),
		.step  (step),
		.frame (frame),
		.done  (done)
	);

endmodule

`default_nettype wire

// File: design/dcache_array.sv
//####################
// dcache array
// valid, dirty, tag and data storage for 16 frames plus the
// per-set LRU bits; does the tag compare and picks the victim
//####################
`default_nettype none

module dcache_array import dcache_pkg::*; (
	input  logic        CLK,
	input  logic        nRST,
	input  word_t       addr,
	input  word_t       wdata,
	input  array_cmd_t  cmd,
	input  word_t       mem_rdata,
	output lookup_t     lookup,
	output word_t       rdata,
	output tag_t        flush_tag,
	output logic        flush_dirty,
	output word_t [1:0] flush_words
);

	// control bits, cleared on reset
	logic [N_SETS-1:0][N_WAYS-1:0] valid;
	logic [N_SETS-1:0][N_WAYS-1:0] dirty;
	logic [N_SETS-1:0]             lru;  // names the way to evict next

	// payload
	tag_t        tags [N_SETS][N_WAYS];
	word_t [1:0] data [N_SETS][N_WAYS];

	tag_t              tag;
	idx_t              idx;
	logic              off;
	logic [N_WAYS-1:0] match;
	logic              vway;
	idx_t              fidx;
	logic              fway;

	// address fields
	assign tag = addr[IDX_W+3 +: TAG_W];
	assign idx = addr[3 +: IDX_W];
	assign off = addr[2];  // word within block

	always_comb begin
		for (int w = 0; w < N_WAYS; w++) begin
			match[w] = valid[idx][w] && (tags[idx][w] == tag);
		end
	end

	// empty way wins, else whatever LRU points at
	always_comb begin
		if (!valid[idx][0]) begin
			vway = 1'b0;
		end else if (!valid[idx][1]) begin
			vway = 1'b1;
		end else begin
			vway = lru[idx];
		end
	end

	always_comb begin
		lookup.hit          = |match;
		lookup.hit_way      = match[1];  // at most one way matches
		lookup.victim_way   = vway;
		lookup.victim_dirty = dirty[idx][vway];
		lookup.victim_tag   = tags[idx][vway];
		lookup.victim_words = data[idx][vway];
	end

	assign rdata = data[idx][match[1]][off];

	// flush side looks at the frame the counter names
	assign fidx        = cmd.frame[$bits(frame_t)-1:1];
	assign fway        = cmd.frame[0];
	assign flush_tag   = tags[fidx][fway];
	assign flush_dirty = dirty[fidx][fway];
	assign flush_words = data[fidx][fway];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid <= '0;
			dirty <= '0;
			lru   <= '0;
		end else begin
			case (cmd.op)
				OP_NONE: begin
					if (lookup.hit) begin
						lru[idx] <= ~lookup.hit_way;  // read hit touches LRU
					end
				end
				OP_STORE: begin
					dirty[idx][cmd.way] <= 1'b1;
					lru[idx]            <= ~cmd.way;
				end
				OP_FILL0: begin
					// old block is gone once the tag changes
					valid[idx][cmd.way] <= 1'b0;
					dirty[idx][cmd.way] <= 1'b0;
				end
				OP_FILL1: begin
					valid[idx][cmd.way] <= 1'b1;
					lru[idx]            <= ~cmd.way;
				end
				OP_CLEAN: dirty[idx][cmd.way] <= 1'b0;
				OP_INVAL: begin
					valid[fidx][fway] <= 1'b0;
					dirty[fidx][fway] <= 1'b0;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		case (cmd.op)
			OP_STORE: data[idx][cmd.way][off] <= wdata;
			OP_FILL0: begin
				tags[idx][cmd.way]    <= tag;
				data[idx][cmd.way][0] <= mem_rdata;
			end
			OP_FILL1: data[idx][cmd.way][1] <= mem_rdata;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: design/dcache_ctrl.sv
//####################
// dcache controller
// FSM for hits, victim writeback, block fill and the halt
// flush; drives the array commands and the memory strobes
//####################
`default_nettype none

module dcache_ctrl import dcache_pkg::*; (
	input  logic        CLK,
	input  logic        nRST,
	input  cpu_req_t    cpu_req,
	input  logic        halt,
	input  lookup_t     lookup,
	input  word_t       rdata,
	input  tag_t        flush_tag,
	input  logic        flush_dirty,
	input  word_t [1:0] flush_words,
	input  frame_t      frame,
	input  logic        done,
	input  logic        mem_wait,
	output cpu_rsp_t    cpu_rsp,
	output logic        flushed,
	output array_cmd_t  cmd,
	output logic        step,
	output mem_req_t    mem_req
);

	ctrl_state_e state, next_state;

	logic req;
	tag_t req_tag;
	idx_t req_idx;
	idx_t flush_idx;

	// block address of one word
	function automatic word_t blk_addr(input tag_t t, input idx_t i, input logic off);
		return {t, i, off, 2'b00};
	endfunction

	assign req       = cpu_req.ren || cpu_req.wen;
	assign req_tag   = cpu_req.addr[IDX_W+3 +: TAG_W];
	assign req_idx   = cpu_req.addr[3 +: IDX_W];
	assign flush_idx = frame[$bits(frame_t)-1:1];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state    = state;
		cmd.op        = OP_NONE;
		cmd.way       = lookup.victim_way;  // victim stays put during a miss
		cmd.frame     = frame;
		step          = 1'b0;
		flushed       = 1'b0;
		cpu_rsp.hit   = 1'b0;
		cpu_rsp.rdata = rdata;
		mem_req       = '0;

		case (state)
			IDLE: begin
				cmd.way = lookup.hit_way;
				if (req) begin
					if (lookup.hit) begin
						cpu_rsp.hit = 1'b1;
						if (cpu_req.wen) begin
							cmd.op = OP_STORE;
						end
					end else if (lookup.victim_dirty) begin
						next_state = WB0;
					end else begin
						next_state = FILL0;
					end
				end else if (halt) begin
					next_state = FLUSH_CHK;
				end
			end
			WB0: begin
				mem_req.wen   = 1'b1;
				mem_req.addr  = blk_addr(lookup.victim_tag, req_idx, 1'b0);
				mem_req.wdata = lookup.victim_words[0];
				if (!mem_wait) begin
					next_state = WB1;
				end
			end
			WB1: begin
				mem_req.wen   = 1'b1;
				mem_req.addr  = blk_addr(lookup.victim_tag, req_idx, 1'b1);
				mem_req.wdata = lookup.victim_words[1];
				if (!mem_wait) begin
					cmd.op     = OP_CLEAN;  // victim now matches memory
					next_state = FILL0;
				end
			end
			FILL0: begin
				mem_req.ren  = 1'b1;
				mem_req.addr = blk_addr(req_tag, req_idx, 1'b0);
				if (!mem_wait) begin
					cmd.op     = OP_FILL0;
					next_state = FILL1;
				end
			end
			FILL1: begin
				mem_req.ren  = 1'b1;
				mem_req.addr = blk_addr(req_tag, req_idx, 1'b1);
				if (!mem_wait) begin
					cmd.op     = OP_FILL1;
					next_state = IDLE;  // request then hits
				end
			end
			FLUSH_CHK: begin
				if (done) begin
					flushed    = 1'b1;
					next_state = FLUSHED;
				end else if (flush_dirty) begin
					next_state = FLUSH_W1;
				end else begin
					step = 1'b1;  // clean frame, skip it
				end
			end
			FLUSH_W1: begin
				mem_req.wen   = 1'b1;
				mem_req.addr  = blk_addr(flush_tag, flush_idx, 1'b1);
				mem_req.wdata = flush_words[1];
				if (!mem_wait) begin
					next_state = FLUSH_W0;
				end
			end
			FLUSH_W0: begin
				mem_req.wen   = 1'b1;
				mem_req.addr  = blk_addr(flush_tag, flush_idx, 1'b0);
				mem_req.wdata = flush_words[0];
				if (!mem_wait) begin
					cmd.op     = OP_INVAL;
					step       = 1'b1;
					next_state = FLUSH_CHK;
				end
			end
			FLUSHED: flushed = 1'b1;  // sticky until reset
			default: next_state = IDLE;
		endcase
	end

endmodule

`default_nettype wire

// File: design/dcache_pkg.sv
//####################
// dcache package
// geometry, field types, request structs and state encodings
// for the two-way write-back data cache
//####################
`default_nettype none

package dcache_pkg;

	// geometry
	localparam int WORD_W   = 32;
	localparam int TAG_W    = 26;  // addr[31:6]
	localparam int IDX_W    = 3;   // addr[5:3]
	localparam int N_SETS   = 8;
	localparam int N_WAYS   = 2;
	localparam int N_FRAMES = N_SETS * N_WAYS;

	typedef logic [WORD_W-1:0]            word_t;
	typedef logic [TAG_W-1:0]             tag_t;
	typedef logic [IDX_W-1:0]             idx_t;
	typedef logic [$clog2(N_FRAMES)-1:0]  frame_t;  // {set index, way}

	typedef enum logic [2:0] {
		OP_NONE,
		OP_STORE,
		OP_FILL0,
		OP_FILL1,
		OP_CLEAN,
		OP_INVAL
	} array_op_e;

	typedef enum logic [3:0] {
		IDLE,
		WB0,
		WB1,
		FILL0,
		FILL1,
		FLUSH_CHK,
		FLUSH_W1,
		FLUSH_W0,
		FLUSHED
	} ctrl_state_e;

	typedef struct packed {
		logic  ren;
		logic  wen;
		word_t addr;
		word_t wdata;
	} cpu_req_t;

	typedef struct packed {
		logic  hit;
		word_t rdata;
	} cpu_rsp_t;

	typedef struct packed {
		logic  ren;
		logic  wen;
		word_t addr;
		word_t wdata;
	} mem_req_t;

	typedef struct packed {
		array_op_e op;
		logic      way;
		frame_t    frame;  // only read by flush ops
	} array_cmd_t;

	typedef struct packed {
		logic        hit;
		logic        hit_way;
		logic        victim_way;
		logic        victim_dirty;
		tag_t        victim_tag;
		word_t [1:0] victim_words;
	} lookup_t;

endpackage

`default_nettype wire

// File: design/flush_counter.sv
//####################
// flush counter
// walks frames 0..15 one per step, then holds done
//####################
`default_nettype none

module flush_counter import dcache_pkg::*; (
	input  logic   CLK,
	input  logic   nRST,
	input  logic   step,
	output frame_t frame,
	output logic   done
);

	// one extra bit so the count can sit past the last frame
	logic [$bits(frame_t):0] count;

	assign frame = count[$bits(frame_t)-1:0];
	assign done  = (count == N_FRAMES);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			count <= '0;
		end else if (step && !done) begin
			count <= count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: sim/dcache_tb.sv
//####################
// dcache testbench
// drives loads, stores and halt, keeps a reference memory
// image and checks the cache and memory side
//####################
`default_nettype none

module dcache_tb import dcache_pkg::*; ();

	localparam int CLK_PERIOD  = 20;
	localparam int DRIVE_DLY   = 2;
	localparam int N_TESTS     = 6;
	localparam int WORST_WORD  = 4;  // three wait cycles plus the transfer
	localparam int FLUSH_WORST = N_FRAMES * (1 + 2 * WORST_WORD);
	localparam int WATCHDOG    = N_TESTS * FLUSH_WORST * 10;
	localparam int N_STRESS    = 24;

	logic     CLK = 1'b0;
	logic     nRST;
	cpu_req_t cpu_req;
	logic     halt;
	cpu_rsp_t cpu_rsp;
	logic     flushed;
	mem_req_t mem_req;
	logic     mem_wait;
	word_t    mem_rdata;

	word_t    ref_mem [word_t];  // stores seen by the cache
	word_t    stored [$];
	mem_req_t held_req;
	logic     held_pending = 1'b0;

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	dcache u_dcache (
		.CLK       (CLK),
		.nRST      (nRST),
		.cpu_req   (cpu_req),
		.halt      (halt),
		.cpu_rsp   (cpu_rsp),
		.flushed   (flushed),
		.mem_req   (mem_req),
		.mem_wait  (mem_wait),
		.mem_rdata (mem_rdata)
	);

	mem_model u_mem_model (
		.CLK       (CLK),
		.nRST      (nRST),
		.mem_req   (mem_req),
		.mem_wait  (mem_wait),
		.mem_rdata (mem_rdata)
	);

	task automatic stop_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_value(input string name, input word_t exp, input word_t act);
		$display("ERROR at %0t: %s expected %h, actual %h", $time, name, exp, act);
		stop_run();
	endtask

	task automatic report_problem(input string what);
		$display("ERROR at %0t: %s", $time, what);
		stop_run();
	endtask

	// memory contents before any write
	function automatic word_t preload_value(input word_t a);
		return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b9);
	endfunction

	function automatic word_t expected_word(input word_t a);
		return ref_mem.exists(a) ? ref_mem[a] : preload_value(a);
	endfunction

	function automatic word_t mem_word(input word_t a);
		return u_mem_model.mem[a[11:2]];
	endfunction

	// tags 8..31 spread over all sets with three blocks per set
	function automatic word_t stress_addr(input int i);
		return word_t'((i + 8) * 64 + (i % 8) * 8 + (i % 2) * 4);
	endfunction

	// hold the request until the cache reports hit
	task automatic cpu_access(input logic is_store, input word_t addr, input word_t data,
			output word_t rdata);
		@(posedge CLK);
		#DRIVE_DLY;
		cpu_req.ren   = !is_store;
		cpu_req.wen   = is_store;
		cpu_req.addr  = addr;
		cpu_req.wdata = data;
		do @(negedge CLK); while (!cpu_rsp.hit);
		rdata = cpu_rsp.rdata;
		@(posedge CLK);
		#DRIVE_DLY;
		cpu_req.ren = 1'b0;
		cpu_req.wen = 1'b0;
	endtask

	task automatic load_check(input word_t addr);
		word_t got;
		word_t exp;
		exp = expected_word(addr);
		cpu_access(1'b0, addr, '0, got);
		assert (got == exp) else report_value("cpu_rsp.rdata", exp, got);
	endtask

	task automatic store_word(input word_t addr, input word_t data);
		word_t unused;
		cpu_access(1'b1, addr, data, unused);
		if (!ref_mem.exists(addr)) begin
			stored.push_back(addr);
		end
		ref_mem[addr] = data;
	endtask

	task automatic expect_xfers(input int unsigned base, input int unsigned n);
		assert (u_mem_model.xfer_count == base + n)
			else report_value("xfer_count", base + n, u_mem_model.xfer_count);
	endtask

	strobes_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
		!(mem_req.ren && mem_req.wen))
		else report_problem("mem_req.ren and mem_req.wen were high together");
	flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
		flushed |=> flushed)
		else report_problem("flushed dropped after it had risen");
	quiet_after_flush: assert property (@(posedge CLK) disable iff (!nRST)
		flushed |-> !(mem_req.ren || mem_req.wen))
		else report_problem("memory request issued after flushed rose");

	// request held while memory stalls
	always @(negedge CLK) begin
		if (held_pending) begin
			assert (mem_req.ren == held_req.ren && mem_req.wen == held_req.wen)
				else report_problem("memory strobe changed while mem_wait was high");
			assert (mem_req.addr == held_req.addr)
				else report_value("mem_req.addr", held_req.addr, mem_req.addr);
			assert (mem_req.wdata == held_req.wdata)
				else report_value("mem_req.wdata", held_req.wdata, mem_req.wdata);
		end
		held_pending <= nRST && (mem_req.ren || mem_req.wen) && mem_wait;
		held_req     <= mem_req;
	end

	initial begin
		#(WATCHDOG * CLK_PERIOD);
		report_problem("watchdog expired before the tests finished");
	end

	initial begin
		int unsigned base;
		int unsigned log_base;
		nRST    = 1'b0;
		halt    = 1'b0;
		cpu_req = '0;
		repeat (16) @(posedge CLK);
		#DRIVE_DLY;
		nRST = 1'b1;

		@(negedge CLK);
		assert (!cpu_rsp.hit) else report_value("cpu_rsp.hit", 0, cpu_rsp.hit);
		assert (!mem_req.ren) else report_value("mem_req.ren", 0, mem_req.ren);
		assert (!mem_req.wen) else report_value("mem_req.wen", 0, mem_req.wen);
		assert (!flushed) else report_value("flushed", 0, flushed);

		// load miss fills, other word then hits
		base = u_mem_model.xfer_count;
		load_check(32'h0c8);
		expect_xfers(base, 2);
		load_check(32'h0cc);
		expect_xfers(base, 2);

		// store hit, then store miss that allocates
		base = u_mem_model.xfer_count;
		store_word(32'h0cc, 32'h1234_5678);
		load_check(32'h0cc);
		expect_xfers(base, 0);
		store_word(32'h15c, 32'hcafe_f00d);
		expect_xfers(base, 2);
		load_check(32'h15c);
		expect_xfers(base, 2);

		// A and B share set 4 with B dirty and A touched last
		load_check(32'h060);
		load_check(32'h0a0);
		store_word(32'h0a4, 32'hbeef_0004);
		load_check(32'h060);
		log_base = u_mem_model.wr_log.size();
		load_check(32'h1a0);  // C evicts B
		assert (u_mem_model.wr_log.size() >= log_base + 2)
			else report_problem("dirty LRU victim was not written back");
		assert (u_mem_model.wr_log[log_base] == 32'h0a0)
			else report_value("mem_req.addr", 32'h0a0, u_mem_model.wr_log[log_base]);
		assert (u_mem_model.wr_log[log_base + 1] == 32'h0a4)
			else report_value("mem_req.addr", 32'h0a4, u_mem_model.wr_log[log_base + 1]);
		assert (mem_word(32'h0a0) == expected_word(32'h0a0))
			else report_value("mem_model.mem", expected_word(32'h0a0), mem_word(32'h0a0));
		assert (mem_word(32'h0a4) == expected_word(32'h0a4))
			else report_value("mem_model.mem", expected_word(32'h0a4), mem_word(32'h0a4));
		base = u_mem_model.xfer_count;
		load_check(32'h064);
		expect_xfers(base, 0);

		// conflict traffic with lots of dirty evictions
		for (int i = 0; i < N_STRESS; i++) begin
			store_word(stress_addr(i), 32'hc0de_0000 + i);
		end
		for (int i = N_STRESS - 1; i >= 0; i--) begin
			load_check(stress_addr(i));
		end

		@(posedge CLK);
		#DRIVE_DLY;
		halt = 1'b1;
		do @(negedge CLK); while (!flushed);
		repeat (20) @(negedge CLK);
		foreach (stored[i]) begin
			assert (mem_word(stored[i]) == ref_mem[stored[i]])
				else report_value("mem_model.mem", ref_mem[stored[i]], mem_word(stored[i]));
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/mem_model.sv
//####################
// memory model
// word memory behind the cache with random wait states,
// a transfer count and a log of written addresses
//####################
`default_nettype none

module mem_model import dcache_pkg::*; (
	input  logic     CLK,
	input  logic     nRST,
	input  mem_req_t mem_req,
	output logic     mem_wait,
	output word_t    mem_rdata
);

	localparam int DEPTH = 1024;  // byte addresses below 4 KiB

	word_t       mem [DEPTH];
	integer      seed;
	logic [1:0]  wait_cnt;        // wait cycles left for the current transfer
	logic        active;
	int unsigned xfer_count;
	word_t       wr_log [$];

	// preload value, mixes every address bit
	function automatic word_t fill_word(input word_t a);
		return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b9);
	endfunction

	initial begin
		seed = 59222;
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = fill_word(word_t'(i * 4));
		end
	end

	assign active    = mem_req.ren || mem_req.wen;
	assign mem_wait  = active && (wait_cnt != 2'd0);
	assign mem_rdata = mem[mem_req.addr[11:2]];

	always @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wait_cnt   <= 2'd1;
			xfer_count <= 0;
		end else if (active) begin
			if (wait_cnt != 2'd0) begin
				wait_cnt <= wait_cnt - 2'd1;
			end else begin
				wait_cnt   <= 2'($random(seed));  // wait for the next transfer
				xfer_count <= xfer_count + 1;
				if (mem_req.wen) begin
					mem[mem_req.addr[11:2]] <= mem_req.wdata;
					wr_log.push_back(mem_req.addr);
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: vlog.f
design/dcache_pkg.sv
design/dcache_array.sv
design/flush_counter.sv
design/dcache_ctrl.sv
design/dcache.sv
sim/mem_model.sv
sim/dcache_tb.sv
